// File: hdl/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// data path and address width
`define SOC_XLEN 32

// word address bits of the ram, taken from byte address bits 12..2
`define SOC_RAM_AW 11

// machine timer registers
`define SOC_MTIME_ADDR    32'h0002_0000
`define SOC_MTIMECMP_ADDR 32'h0002_0008

// uart registers
`define SOC_UART_DATA_ADDR 32'h0002_1000
`define SOC_UART_STAT_ADDR 32'h0002_1004

// clocks per uart bit
`define SOC_UART_CLKS_PER_BIT 8

`endif

// File: hdl/soc_pkg.sv
`include "soc_consts.svh"

package soc_pkg;

   // data word and byte address
   typedef logic [`SOC_XLEN-1:0] word_t;
   typedef logic [`SOC_XLEN-1:0] addr_t;

   // one uart character
   typedef logic [7:0] byte_t;

   // word offset handed to a target
   typedef logic [`SOC_RAM_AW-1:0] offset_t;

   // decoded target of a bus access
   typedef enum logic [1:0] {tgt_ram, tgt_timer, tgt_uart, tgt_none} target_e;

endpackage

// File: hdl/periph_bus_if.sv
// per-target link between decoder and one peripheral
interface periph_bus_if import soc_pkg::*; ();

   // one-cycle strobes, never both high
   logic    we;
   logic    re;

   // word offset from address bits 12..2
   offset_t offset;

   word_t   wdata;

   // registered by the target, valid the cycle after re
   word_t   rdata;

   modport master (output we, output re, output offset, output wdata, input rdata);

   modport target (input we, input re, input offset, input wdata, output rdata);

endinterface

// File: hdl/addr_decode.sv
`include "soc_consts.svh"

module addr_decode import soc_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  addr_t               bus_addr,
   input  word_t               bus_wdata,
   input  logic                bus_we,
   input  logic                bus_re,
   output word_t               bus_rdata,
   output logic                bus_rvalid,
   periph_bus_if.master        ram,
   periph_bus_if.master        timer,
   periph_bus_if.master        uart
);

   target_e tgt;
   target_e rd_tgt_q;

   // classify the byte address
   always_comb
   begin
      if (bus_addr[`SOC_XLEN-1:16] == '0)
         tgt = tgt_ram;
      else if (bus_addr == `SOC_MTIME_ADDR || bus_addr == `SOC_MTIMECMP_ADDR)
         tgt = tgt_timer;
      else if (bus_addr == `SOC_UART_DATA_ADDR || bus_addr == `SOC_UART_STAT_ADDR)
         tgt = tgt_uart;
      else
         tgt = tgt_none;   // display window and holes land here
   end

   // strobes only reach the selected target
   assign ram.we   = bus_we && (tgt == tgt_ram);
   assign ram.re   = bus_re && (tgt == tgt_ram);
   assign timer.we = bus_we && (tgt == tgt_timer);
   assign timer.re = bus_re && (tgt == tgt_timer);
   assign uart.we  = bus_we && (tgt == tgt_uart);
   assign uart.re  = bus_re && (tgt == tgt_uart);

   // offset and data are broadcast
   assign ram.offset   = bus_addr[`SOC_RAM_AW+1:2];
   assign timer.offset = bus_addr[`SOC_RAM_AW+1:2];
   assign uart.offset  = bus_addr[`SOC_RAM_AW+1:2];
   assign ram.wdata    = bus_wdata;
   assign timer.wdata  = bus_wdata;
   assign uart.wdata   = bus_wdata;

   // remember who answers the read in the next cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_tgt_q   <= tgt_none;
         bus_rvalid <= 1'b0;
      end
      else
      begin
         bus_rvalid <= bus_re;
         if (bus_re)
            rd_tgt_q <= tgt;
      end
   end

   // return mux, unmapped reads give zero
   always_comb
   begin
      case (rd_tgt_q)
         tgt_ram:   bus_rdata = ram.rdata;
         tgt_timer: bus_rdata = timer.rdata;
         tgt_uart:  bus_rdata = uart.rdata;
         default:   bus_rdata = '0;
      endcase
   end

endmodule

// File: hdl/data_ram.sv
`include "soc_consts.svh"

module data_ram import soc_pkg::*; (
   input  logic         clk,
   periph_bus_if.target bus
);

   localparam int DEPTH = 2 ** `SOC_RAM_AW;

   // 2048 words of storage
   word_t mem [DEPTH];

   // write port
   always_ff @(posedge clk)
   begin
      if (bus.we)
         mem[bus.offset] <= bus.wdata;
   end

   // registered read, one cycle latency
   // we and re never coincide, so no bypass needed
   always_ff @(posedge clk)
   begin
      if (bus.re)
         bus.rdata <= mem[bus.offset];
   end

endmodule

// File: hdl/machine_timer.sv
`include "soc_consts.svh"

module machine_timer import soc_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   periph_bus_if.target bus,
   input  logic         mtie,
   output logic         timer_irq
);

   word_t mtime;
   word_t mtimecmp;
   logic  sel_cmp;

   // offset bit 1 is address bit 3, picks mtimecmp
   assign sel_cmp = bus.offset[1];

   // free-running counter, a write reloads it
   always_ff @(posedge clk)
   begin
      if (reset)
         mtime <= '0;
      else if (bus.we && !sel_cmp)
         mtime <= bus.wdata;
      else
         mtime <= mtime + 1'b1;
   end

   // compare register, all ones keeps the irq quiet
   always_ff @(posedge clk)
   begin
      if (reset)
         mtimecmp <= '1;
      else if (bus.we && sel_cmp)
         mtimecmp <= bus.wdata;
   end

   // irq registered, gated by mtie
   always_ff @(posedge clk)
   begin
      if (reset)
         timer_irq <= 1'b0;
      else
         timer_irq <= mtie && (mtime >= mtimecmp);
   end

   // read word captured at the strobe edge
   always_ff @(posedge clk)
   begin
      if (bus.re)
         bus.rdata <= sel_cmp ? mtimecmp : mtime;
   end

endmodule

// File: hdl/uart_port.sv
`include "soc_consts.svh"

module uart_port import soc_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   periph_bus_if.target bus,
   input  logic         rxd,
   output logic         txd,
   output logic         rx_irq
);

   localparam int CPB = `SOC_UART_CLKS_PER_BIT;
   localparam int CW  = $clog2(CPB);

   typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

   tx_state_e       tx_state;
   logic [CW-1:0]   tx_baud;
   logic [2:0]      tx_bit;
   byte_t           tx_shift;
   logic            tx_baud_done;
   logic            tx_busy;
   logic            data_wr;

   rx_state_e       rx_state;
   logic [CW-1:0]   rx_baud;
   logic [2:0]      rx_bit;
   byte_t           rx_shift;
   byte_t           rx_data_q;
   logic            rx_fresh;
   logic            rx_meta;
   logic            rx_sync;
   logic            rx_baud_done;
   logic            rx_good_stop;

   // offset bit 0 picks status over data
   assign data_wr      = bus.we && !bus.offset[0];
   assign tx_busy      = (tx_state != tx_idle);
   assign tx_baud_done = (tx_baud == CW'(CPB - 1));

   // tx fsm; writes while busy are dropped
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_state <= tx_idle;
         tx_baud  <= '0;
         tx_bit   <= '0;
      end
      else
      begin
         tx_baud <= tx_baud_done ? '0 : tx_baud + 1'b1;
         case (tx_state)
            tx_idle:
            begin
               tx_baud <= '0;
               if (data_wr)
                  tx_state <= tx_start;
            end
            tx_start:
               if (tx_baud_done)
               begin
                  tx_state <= tx_data;
                  tx_bit   <= '0;
               end
            tx_data:
               if (tx_baud_done)
               begin
                  if (tx_bit == 3'd7)
                     tx_state <= tx_stop;
                  tx_bit <= tx_bit + 1'b1;
               end
            default:
               if (tx_baud_done)
                  tx_state <= tx_idle;
         endcase
      end
   end

   // shift register, lsb goes out first
   always_ff @(posedge clk)
   begin
      if (tx_state == tx_idle && data_wr)
         tx_shift <= bus.wdata[7:0];
      else if (tx_state == tx_data && tx_baud_done)
         tx_shift <= tx_shift >> 1;
   end

   // line follows the state one clock later
   always_ff @(posedge clk)
   begin
      if (reset)
         txd <= 1'b1;
      else if (tx_state == tx_start)
         txd <= 1'b0;
      else if (tx_state == tx_data)
         txd <= tx_shift[0];
      else
         txd <= 1'b1;
   end

   // two-flop sync on rxd
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
      end
   end

   assign rx_baud_done = (rx_baud == CW'(CPB - 1));
   assign rx_good_stop = (rx_state == rx_stop) && rx_baud_done && rx_sync;

   // rx fsm, samples mid-bit
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_state <= rx_idle;
         rx_baud  <= '0;
         rx_bit   <= '0;
      end
      else
      begin
         rx_baud <= rx_baud_done ? '0 : rx_baud + 1'b1;
         case (rx_state)
            rx_idle:
            begin
               rx_baud <= '0;
               if (!rx_sync)
                  rx_state <= rx_start;
            end
            rx_start:
               // half a bit in, recheck the start level
               if (rx_baud == CW'(CPB / 2 - 1))
               begin
                  rx_baud  <= '0;
                  rx_bit   <= '0;
                  rx_state <= rx_sync ? rx_idle : rx_data;
               end
            rx_data:
               if (rx_baud_done)
               begin
                  if (rx_bit == 3'd7)
                     rx_state <= rx_stop;
                  rx_bit <= rx_bit + 1'b1;
               end
            default:
               if (rx_baud_done)
                  rx_state <= rx_idle;   // bad stop bit just drops the frame
         endcase
      end
   end

   // received bits enter at the top
   always_ff @(posedge clk)
   begin
      if (rx_state == rx_data && rx_baud_done)
         rx_shift <= {rx_sync, rx_shift[7:1]};
      if (rx_good_stop)
         rx_data_q <= rx_shift;
   end

   // fresh flag and irq pulse
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_fresh <= 1'b0;
         rx_irq   <= 1'b0;
      end
      else
      begin
         rx_irq <= rx_good_stop;
         if (rx_good_stop)
            rx_fresh <= 1'b1;
         else if (bus.re && !bus.offset[0])
            rx_fresh <= 1'b0;
      end
   end

   // status is {fresh, busy} in the low bits
   always_ff @(posedge clk)
   begin
      if (bus.re)
         bus.rdata <= bus.offset[0] ? word_t'({rx_fresh, tx_busy}) : word_t'(rx_data_q);
   end

endmodule

// File: hdl/soc_top.sv
`include "soc_consts.svh"

module soc_top import soc_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  addr_t bus_addr,
   input  word_t bus_wdata,
   input  logic  bus_we,
   input  logic  bus_re,
   input  logic  mtie,
   input  logic  uart_rxd,
   output word_t bus_rdata,
   output logic  bus_rvalid,
   output logic  timer_irq,
   output logic  rx_irq,
   output logic  uart_txd
);

   // one link per target
   periph_bus_if ram_bus ();
   periph_bus_if timer_bus ();
   periph_bus_if uart_bus ();

   addr_decode u_decode (
      .clk        (clk),
      .reset      (reset),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_we     (bus_we),
      .bus_re     (bus_re),
      .bus_rdata  (bus_rdata),
      .bus_rvalid (bus_rvalid),
      .ram        (ram_bus.master),
      .timer      (timer_bus.master),
      .uart       (uart_bus.master)
   );

   data_ram u_ram (
      .clk (clk),
      .bus (ram_bus.target)
   );

   machine_timer u_timer (
      .clk       (clk),
      .reset     (reset),
      .bus       (timer_bus.target),
      .mtie      (mtie),
      .timer_irq (timer_irq)
   );

   // rx irq goes straight out, no interrupt controller here
   uart_port u_uart (
      .clk    (clk),
      .reset  (reset),
      .bus    (uart_bus.target),
      .rxd    (uart_rxd),
      .txd    (uart_txd),
      .rx_irq (rx_irq)
   );

endmodule

// File: dv/soc_properties.sv
module soc_properties (
   input logic clk,
   input logic reset,
   input logic bus_re,
   input logic bus_rvalid,
   input logic mtie,
   input logic timer_irq,
   input logic rx_irq
);

   // read answer exactly one cycle after the strobe
   rvalid_follows_re: assert property (@(posedge clk) disable iff (reset)
      bus_rvalid == $past(bus_re))
      else $error("bus_rvalid does not follow bus_re by one cycle");

   // irq register only sets from a cycle with mtie high
   irq_needs_mtie: assert property (@(posedge clk) disable iff (reset)
      $rose(timer_irq) |-> $past(mtie))
      else $error("timer_irq rose while mtie was low");

   // receive irq is a single-cycle pulse
   rx_irq_one_cycle: assert property (@(posedge clk) disable iff (reset)
      $past(rx_irq) |-> !rx_irq)
      else $error("rx_irq stayed high for more than one cycle");

endmodule

bind soc_top soc_properties u_props (
   .clk        (clk),
   .reset      (reset),
   .bus_re     (bus_re),
   .bus_rvalid (bus_rvalid),
   .mtie       (mtie),
   .timer_irq  (timer_irq),
   .rx_irq     (rx_irq)
);

// File: dv/soc_tb.sv
`include "soc_consts.svh"

module soc_tb import soc_pkg::*; ();

   // tests need a few hundred cycles, this leaves plenty of margin
   localparam int TIMEOUT_CYCLES = 3000;
   // edges between the mtime write and the read strobe
   localparam int MTIME_WAIT     = 7;

   logic   clk = 1'b0;
   logic   reset;
   addr_t  bus_addr;
   word_t  bus_wdata;
   logic   bus_we;
   logic   bus_re;
   logic   mtie;
   word_t  bus_rdata;
   logic   bus_rvalid;
   logic   timer_irq;
   logic   rx_irq;
   logic   uart_txd;

   integer seed = 96673;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   int     rx_irq_count = 0;
   addr_t  ram_addr [16];
   word_t  ram_data [16];

   // uart looped back, txd feeds rxd
   soc_top uut (
      .clk        (clk),
      .reset      (reset),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_we     (bus_we),
      .bus_re     (bus_re),
      .mtie       (mtie),
      .uart_rxd   (uart_txd),
      .bus_rdata  (bus_rdata),
      .bus_rvalid (bus_rvalid),
      .timer_irq  (timer_irq),
      .rx_irq     (rx_irq),
      .uart_txd   (uart_txd)
   );

   always #4 clk = ~clk;

   // count rx pulses mid-cycle where the output is settled
   always @(negedge clk)
   begin
      if (rx_irq)
         rx_irq_count++;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("timeout, tests still running after %0d cycles", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic expect_rvalid(input addr_t addr);
      checks++;
      if (!bus_rvalid)
      begin
         $display("bus_rvalid missing in the cycle after the read of %h", addr);
         errors++;
      end
   endtask

   // write strobe, takes effect at the next rising edge
   task automatic write_word(input addr_t addr, input word_t data);
      @(negedge clk);
      bus_addr  = addr;
      bus_wdata = data;
      bus_we    = 1'b1;
      @(negedge clk);
      bus_we = 1'b0;
   endtask

   // read strobe, answer due in the very next cycle
   task automatic read_word(input addr_t addr, output word_t data);
      @(negedge clk);
      bus_addr = addr;
      bus_re   = 1'b1;
      @(negedge clk);
      bus_re = 1'b0;
      data   = bus_rdata;
      expect_rvalid(addr);
   endtask

   task automatic mtimecmp_reset_value();
      word_t data;
      read_word(`SOC_MTIMECMP_ADDR, data);
      check_word("mtimecmp after reset", '1, data);
   endtask

   task automatic ram_readback();
      word_t rnd;
      word_t data;
      int    i;
      for (i = 0; i < 16; i++)
      begin
         rnd = $random(seed);
         // index in the low offset bits keeps all 16 words apart
         ram_addr[i] = {19'd0, rnd[10:4], 4'(i), 2'b00};
         ram_data[i] = $random(seed);
         write_word(ram_addr[i], ram_data[i]);
      end
      for (i = 0; i < 16; i++)
      begin
         read_word(ram_addr[i], data);
         check_word("ram single read", ram_data[i], data);
      end
      // back to back, one read in flight while the next strobe goes out
      for (i = 0; i <= 16; i++)
      begin
         @(negedge clk);
         if (i > 0)
         begin
            expect_rvalid(ram_addr[i-1]);
            check_word("ram burst read", ram_data[i-1], bus_rdata);
         end
         bus_re   = (i < 16);
         bus_addr = ram_addr[i % 16];
      end
   endtask

   task automatic mtime_load();
      word_t data;
      write_word(`SOC_MTIME_ADDR, 32'd1000);
      // read_word adds two edges of its own
      repeat (MTIME_WAIT - 2) @(negedge clk);
      read_word(`SOC_MTIME_ADDR, data);
      check_word("mtime after load", word_t'(1000 + MTIME_WAIT - 1), data);
   endtask

   task automatic timer_irq_gating();
      word_t now;
      int    i;
      // compare already met, enable still low
      write_word(`SOC_MTIMECMP_ADDR, 32'd10);
      for (i = 0; i < 4; i++)
      begin
         @(negedge clk);
         check_word("timer irq masked", 0, word_t'(timer_irq));
      end
      mtie = 1'b1;
      @(negedge clk);
      check_word("timer irq enabled", 1, word_t'(timer_irq));
      read_word(`SOC_MTIME_ADDR, now);
      write_word(`SOC_MTIMECMP_ADDR, now + 32'd500);
      @(negedge clk);
      check_word("timer irq after compare moved", 0, word_t'(timer_irq));
      mtie = 1'b0;
   endtask

   task automatic uart_loopback();
      word_t status;
      word_t data;
      int    polls;
      int    irq_before;
      irq_before = rx_irq_count;
      write_word(`SOC_UART_DATA_ADDR, 32'h0000_00A5);
      // lands mid-frame, transmitter must drop it
      write_word(`SOC_UART_DATA_ADDR, 32'h0000_003C);
      polls  = 0;
      status = 32'h1;
      while (status[0] && polls < 200)
      begin
         read_word(`SOC_UART_STAT_ADDR, status);
         polls++;
      end
      checks++;
      if (status[0])
      begin
         $display("uart transmitter still busy after %0d status polls", polls);
         errors++;
      end
      check_word("uart rx irq pulses", 1, word_t'(rx_irq_count - irq_before));
      check_word("uart fresh after frame", 1, word_t'(status[1]));
      read_word(`SOC_UART_DATA_ADDR, data);
      check_word("uart loopback byte", 32'h0000_00A5, data);
      read_word(`SOC_UART_STAT_ADDR, status);
      check_word("uart fresh after data read", 0, word_t'(status[1]));
      // a whole frame time more, no second byte may show up
      repeat (12 * `SOC_UART_CLKS_PER_BIT) @(negedge clk);
      check_word("uart dropped second byte", 1, word_t'(rx_irq_count - irq_before));
   endtask

   task automatic unmapped_access();
      word_t data;
      write_word(32'h0000_0000, 32'h1357_9BDF);
      // display window shares offset 0 with ram word 0
      write_word(32'h0001_0000, 32'hDEAD_BEEF);
      read_word(32'h0000_0000, data);
      check_word("ram word 0 after display write", 32'h1357_9BDF, data);
      read_word(32'h0001_0000, data);
      check_word("display window read", 0, data);
      read_word(32'h0003_0000, data);
      check_word("unmapped read", 0, data);
   endtask

   initial
   begin
      reset     = 1'b1;
      bus_addr  = '0;
      bus_wdata = '0;
      bus_we    = 1'b0;
      bus_re    = 1'b0;
      mtie      = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      // {rvalid, timer_irq, rx_irq, txd}
      check_word("outputs after reset", 32'h1,
                 word_t'({bus_rvalid, timer_irq, rx_irq, uart_txd}));
      mtimecmp_reset_value();
      ram_readback();
      mtime_load();
      timer_irq_gating();
      uart_loopback();
      unmapped_access();
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: project.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/periph_bus_if.sv
hdl/addr_decode.sv
hdl/data_ram.sv
hdl/machine_timer.sv
hdl/uart_port.sv
hdl/soc_top.sv
dv/soc_properties.sv
dv/soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# one binary holding the design, the bound checker and the testbench
verilator --binary --timing --assert -f project.f --top-module soc_tb -o soc_sim

sim_output=$(./obj_dir/soc_sim)
echo "$sim_output"

if grep -qx "RESULT: PASS" <<< "$sim_output"; then
   exit 0
fi
exit 1
